//--- common/ll_pkg.sv
// Shared link widths, beat field positions and the PHY word union, imported by RTL and bench
`default_nettype none

package ll_pkg;

  //////////////////////////////////////////////////////////////////////
  // Link widths

  // One PHY channel word
  localparam int phy_w = 80;
  // One stream beat with tvalid folded in
  localparam int st_w = 74;
  // Online and strobe delay values
  localparam int dly_w = 16;
  // Half beat carried per gen1 word
  localparam int half_w = 37;

  //////////////////////////////////////////////////////////////////////
  // Stream beat layout

  localparam int st_tdata_lsb  = 0;
  localparam int st_tdata_msb  = 63;
  localparam int st_tkeep_lsb  = 64;
  localparam int st_tkeep_msb  = 71;
  localparam int st_tlast_bit  = 72;
  localparam int st_tvalid_bit = 73;

  //////////////////////////////////////////////////////////////////////
  // PHY word views

  // Full rate, whole beat per word
  typedef struct packed {
    logic              mrk;
    logic [1:0]        rsvd_hi;
    logic              stb;
    logic [1:0]        rsvd_lo;
    logic [st_w-1:0]   beat;
  } gen2_word_t;

  // Half rate, upper 40 bits idle
  typedef struct packed {
    logic [39:0]       rsvd_hi;
    logic              mrk;
    logic              stb;
    logic              rsvd_lo;
    logic [half_w-1:0] half;
  } gen1_word_t;

  // Same 80 bits, decoded by m_gen2_mode
  typedef union packed {
    gen2_word_t gen2_view;
    gen1_word_t gen1_view;
  } phy_word_u;

endpackage

`default_nettype wire

//--- hdl/ll_auto_sync.sv
// Link bring-up timing, delays online levels and generates the automatic marker and strobe bits
`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync import ll_pkg::*; #(
  parameter bit PERSISTENT_MARKER = 1'b0,
  parameter bit PERSISTENT_STROBE = 1'b0
) (
  input  logic             clk_wr,
  input  logic             rst_n,

  // Raw online levels
  input  logic             tx_online,
  input  logic             rx_online,

  // Programmed delays in clk_wr cycles
  input  logic [dly_w-1:0] delay_x_value,
  input  logic [dly_w-1:0] delay_y_value,
  input  logic [dly_w-1:0] delay_z_value,

  // User requests
  input  logic             tx_mrk_userbit,
  input  logic             tx_stb_userbit,

  output logic             tx_online_delay,
  output logic             rx_online_delay,
  output logic             tx_auto_mrk_userbit,
  output logic             tx_auto_stb_userbit
);

  //////////////////////////////////////////////////////////////////////
  // Online delay counters

  // Index 0 is rx, index 1 is tx
  logic [1:0]       online_in;
  logic [1:0]       online_q;
  logic [dly_w-1:0] dly_val [2];
  logic [dly_w-1:0] dly_cnt [2];

  assign online_in  = {tx_online, rx_online};
  assign dly_val[0] = delay_x_value;
  assign dly_val[1] = delay_y_value;

  for (genvar i = 0; i < 2; i++) begin : g_online
    always_ff @(posedge clk_wr) begin
      if (!rst_n) begin
        online_q[i] <= 1'b0;
        dly_cnt[i]  <= '0;
      end else if (!online_in[i]) begin
        // Offline, keep the count armed and drop at once
        online_q[i] <= 1'b0;
        dly_cnt[i]  <= dly_val[i];
      end else if (!online_q[i]) begin
        // Count down, level rises when empty
        if (dly_cnt[i] == '0) begin
          online_q[i] <= 1'b1;
        end else begin
          dly_cnt[i] <= dly_cnt[i] - 1'b1;
        end
      end
    end
  end

  assign rx_online_delay = online_q[0];
  assign tx_online_delay = online_q[1];

  //////////////////////////////////////////////////////////////////////
  // Strobe spacing

  logic [dly_w-1:0] stb_cnt;
  logic             stb_done;
  logic             stb_q;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      stb_cnt  <= '0;
      stb_done <= 1'b0;
      stb_q    <= 1'b0;
    end else if (!tx_online_delay) begin
      stb_cnt  <= delay_z_value;
      stb_done <= 1'b0;
      stb_q    <= 1'b0;
    end else if (stb_done) begin
      stb_q <= 1'b0;
    end else if (stb_cnt <= 1) begin
      // Period reached
      stb_q   <= PERSISTENT_STROBE ? 1'b1 : tx_stb_userbit;
      stb_cnt <= delay_z_value;
      // Single shot stops here
      stb_done <= ~PERSISTENT_STROBE;
    end else begin
      stb_q   <= 1'b0;
      stb_cnt <= stb_cnt - 1'b1;
    end
  end

  assign tx_auto_stb_userbit = stb_q;

  //////////////////////////////////////////////////////////////////////
  // Marker

  // Never set while tx link is down
  assign tx_auto_mrk_userbit = tx_online_delay & (PERSISTENT_MARKER | tx_mrk_userbit);

endmodule

`default_nettype wire

//--- axi_st_d64_nordy_slave_concat/axi_st_d64_nordy_slave_concat.sv
// PHY side of the slave, unpacks rx words into beats and packs marker and strobe into tx words
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_nordy_slave_concat import ll_pkg::*; (
  input  logic             clk_wr,
  input  logic             rst_n,

  // 1 selects full rate word layout
  input  logic             m_gen2_mode,

  // Delayed online levels
  input  logic             rx_online,
  input  logic             tx_online,

  // Automatic sync bits
  input  logic             tx_mrk_userbit,
  input  logic             tx_stb_userbit,

  // PHY channel
  input  logic [phy_w-1:0] rx_phy0,
  output logic [phy_w-1:0] tx_phy0,

  // Beat toward the user block
  output logic [st_w-1:0]  rx_st_data,
  output logic             rx_st_push,

  output logic             half_sync_err
);

  //////////////////////////////////////////////////////////////////////
  // Receive input register

  phy_word_u rx_word_q;
  logic      rx_vld_q;

  // Word capture every cycle
  always_ff @(posedge clk_wr) begin
    rx_word_q <= rx_phy0;
  end

  // Online level aligned with the captured word
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_vld_q <= 1'b0;
    end else begin
      rx_vld_q <= rx_online;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Gen1 half assembly

  logic              gen1_mrk;
  logic              gen1_act;
  logic [half_w-1:0] lo_half_q;
  logic              half_vld_q;
  logic              half_err_q;

  assign gen1_mrk = rx_word_q.gen1_view.mrk;
  // Decoding a half rate word this cycle
  assign gen1_act = rx_vld_q & ~m_gen2_mode;

  // Low half holding register
  always_ff @(posedge clk_wr) begin
    if (gen1_act && !gen1_mrk) begin
      lo_half_q <= rx_word_q.gen1_view.half;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      half_vld_q <= 1'b0;
      half_err_q <= 1'b0;
    end else if (!gen1_act) begin
      half_vld_q <= 1'b0;
    end else if (!gen1_mrk) begin
      // Newer low half replaces an older one
      half_vld_q <= 1'b1;
    end else begin
      half_vld_q <= 1'b0;
      // High half with nothing to pair with
      if (!half_vld_q) begin
        half_err_q <= 1'b1;
      end
    end
  end

  assign half_sync_err = half_err_q;

  //////////////////////////////////////////////////////////////////////
  // Beat output

  // Gen2 pushes every online word, gen1 only on a paired high half
  assign rx_st_push = rx_vld_q & (m_gen2_mode | (gen1_mrk & half_vld_q));

  assign rx_st_data = m_gen2_mode ? rx_word_q.gen2_view.beat
                                  : {rx_word_q.gen1_view.half, lo_half_q};

  //////////////////////////////////////////////////////////////////////
  // Transmit word

  phy_word_u tx_word;
  phy_word_u tx_word_q;
  logic      tx_phase_q;

  always_comb begin
    tx_word = '0;
    if (m_gen2_mode) begin
      tx_word.gen2_view.mrk = tx_mrk_userbit;
      tx_word.gen2_view.stb = tx_stb_userbit;
    end else begin
      // Marker only on odd phase
      tx_word.gen1_view.mrk = tx_phase_q & tx_mrk_userbit;
      tx_word.gen1_view.stb = tx_stb_userbit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_word_q  <= '0;
      tx_phase_q <= 1'b0;
    end else if (!tx_online) begin
      // Quiet channel, phase restarts at 0
      tx_word_q  <= '0;
      tx_phase_q <= 1'b0;
    end else begin
      tx_word_q  <= tx_word;
      tx_phase_q <= ~tx_phase_q;
    end
  end

  assign tx_phy0 = tx_word_q;

endmodule

`default_nettype wire

//--- hdl/axi_st_d64_nordy_slave_name.sv
// User side of the slave, registers each beat onto the stream ports and keeps debug status
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_nordy_slave_name import ll_pkg::*; (
  input  logic            clk_wr,
  input  logic            rst_n,

  // Beat from the PHY block
  input  logic [st_w-1:0] rx_st_data,
  input  logic            rx_st_push,

  // Status inputs
  input  logic            rx_online,
  input  logic            tx_online,
  input  logic            half_sync_err,

  // Stream channel
  output logic [7:0]      user_tkeep,
  output logic [63:0]     user_tdata,
  output logic            user_tlast,
  output logic            user_tvalid,

  output logic [31:0]     rx_st_debug_status
);

  logic        beat_vld;
  logic [15:0] beat_cnt_q;

  assign beat_vld = rx_st_data[st_tvalid_bit];

  //////////////////////////////////////////////////////////////////////
  // Output register

  // Payload, held between pushes
  always_ff @(posedge clk_wr) begin
    if (rx_st_push) begin
      // Invalid beat shows zeroed fields
      user_tdata <= beat_vld ? rx_st_data[st_tdata_msb:st_tdata_lsb] : '0;
      user_tkeep <= beat_vld ? rx_st_data[st_tkeep_msb:st_tkeep_lsb] : '0;
      user_tlast <= beat_vld & rx_st_data[st_tlast_bit];
    end
  end

  // One cycle pulse per valid beat
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      user_tvalid <= 1'b0;
    end else begin
      user_tvalid <= rx_st_push & beat_vld;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug status

  // Valid beat count, wraps at 16 bits
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
    end else if (rx_st_push && beat_vld) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  assign rx_st_debug_status = {13'b0, half_sync_err, tx_online, rx_online, beat_cnt_q};

endmodule

`default_nettype wire

//--- hdl/axi_st_d64_nordy_slave_top.sv
// Top of the receive-only no-ready AXI-Stream slave, wires sync, PHY and user blocks together
`timescale 1ns/1ps
`default_nettype none

module axi_st_d64_nordy_slave_top import ll_pkg::*; #(
  parameter bit PERSISTENT_MARKER = 1'b0,
  parameter bit PERSISTENT_STROBE = 1'b0
) (
  input  logic             clk_wr,
  input  logic             rst_n,

  // Link control
  input  logic             tx_online,
  input  logic             rx_online,

  // PHY channel
  input  logic [phy_w-1:0] rx_phy0,
  output logic [phy_w-1:0] tx_phy0,

  // Configuration
  input  logic             m_gen2_mode,
  input  logic             tx_mrk_userbit,
  input  logic             tx_stb_userbit,
  input  logic [dly_w-1:0] delay_x_value,
  input  logic [dly_w-1:0] delay_y_value,
  input  logic [dly_w-1:0] delay_z_value,

  // Stream channel
  output logic [7:0]       user_tkeep,
  output logic [63:0]      user_tdata,
  output logic             user_tlast,
  output logic             user_tvalid,

  output logic [31:0]      rx_st_debug_status
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic            tx_online_delay;
  logic            rx_online_delay;
  logic            tx_auto_mrk_userbit;
  logic            tx_auto_stb_userbit;
  logic [st_w-1:0] rx_st_data;
  logic            rx_st_push;
  logic            half_sync_err;

  //////////////////////////////////////////////////////////////////////
  // Link bring-up

  ll_auto_sync #(
    .PERSISTENT_MARKER (PERSISTENT_MARKER),
    .PERSISTENT_STROBE (PERSISTENT_STROBE)
  ) ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY side

  // Sees only the delayed online levels
  axi_st_d64_nordy_slave_concat concat_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .m_gen2_mode    (m_gen2_mode),
    .rx_online      (rx_online_delay),
    .tx_online      (tx_online_delay),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .rx_phy0        (rx_phy0),
    .tx_phy0        (tx_phy0),
    .rx_st_data     (rx_st_data),
    .rx_st_push     (rx_st_push),
    .half_sync_err  (half_sync_err)
  );

  //////////////////////////////////////////////////////////////////////
  // User side

  axi_st_d64_nordy_slave_name name_i (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .rx_st_data         (rx_st_data),
    .rx_st_push         (rx_st_push),
    .rx_online          (rx_online_delay),
    .tx_online          (tx_online_delay),
    .half_sync_err      (half_sync_err),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .rx_st_debug_status (rx_st_debug_status)
  );

endmodule

`default_nettype wire

//--- bench/tb_top.sv
// Top-level testbench that drives PHY words into the slave and checks user beats and tx sync bits
`timescale 1ns/1ps
`default_nettype none

module tb_top import ll_pkg::*; ();

  // Programmed delays
  localparam int dly_x = 5;
  localparam int dly_y = 4;
  localparam int dly_z = 6;
  // PHY word bit positions
  localparam int gen2_mrk_bit = 79;
  localparam int gen2_stb_bit = 76;
  localparam int gen1_mrk_bit = 39;
  localparam int gen1_stb_bit = 38;
  // Cycles watched after tx_online rises
  localparam int tx_win = 18;

  logic             clk_wr;
  logic             rst_n;
  logic             tx_online;
  logic             rx_online;
  logic [phy_w-1:0] rx_phy0;
  logic             m_gen2_mode;
  logic             tx_mrk_userbit;
  logic             tx_stb_userbit;
  logic [dly_w-1:0] delay_x_value;
  logic [dly_w-1:0] delay_y_value;
  logic [dly_w-1:0] delay_z_value;
  logic [phy_w-1:0] tx_phy0;
  logic [7:0]       user_tkeep;
  logic [63:0]      user_tdata;
  logic             user_tlast;
  logic             user_tvalid;
  logic [31:0]      rx_st_debug_status;

  // Expected beats with the cycle they are due in
  logic [st_w-1:0]  exp_q [$];
  int               due_q [$];
  int               rd_idx = 0;
  int               cyc = 0;
  int               last_due;
  int               exp_cnt = 0;
  int               errors = 0;
  int               beat_errors = 0;
  int               tests_failed = 0;

  axi_st_d64_nordy_slave_top dut_i (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .rx_phy0            (rx_phy0),
    .tx_phy0            (tx_phy0),
    .m_gen2_mode        (m_gen2_mode),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .tx_stb_userbit     (tx_stb_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .rx_st_debug_status (rx_st_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #50 clk_wr = ~clk_wr;
  end

  // Cycle index read as the old value at the rising edge
  always @(posedge clk_wr) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference models

  function automatic logic [phy_w-1:0] rand_phy();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[phy_w-1:0];
  endfunction

  // Beat seen on the user ports for one gen2 word or one gen1 pair
  function automatic logic [st_w-1:0] ref_beat(input logic [phy_w-1:0] hi_word,
                                               input logic [phy_w-1:0] lo_word,
                                               input logic gen2);
    logic [st_w-1:0] beat;
    if (gen2) begin
      beat = hi_word[st_w-1:0];
    end else begin
      beat = {hi_word[half_w-1:0], lo_word[half_w-1:0]};
    end
    // Invalid beat shows all fields cleared
    if (!beat[st_tvalid_bit]) begin
      beat = '0;
    end
    return beat;
  endfunction

  // tx_phy0 k cycles after tx_online is driven high
  function automatic logic [phy_w-1:0] tx_ref(input int k, input logic gen2,
                                              input logic mrk_prev);
    int               on_k;
    int               stb_k;
    logic [phy_w-1:0] w;
    // One cycle to sample, delay, then the tx register
    on_k  = 2 + dly_y;
    stb_k = 2 + dly_y + dly_z;
    w = '0;
    if (k >= on_k) begin
      if (gen2) begin
        w[gen2_mrk_bit] = mrk_prev;
        w[gen2_stb_bit] = (k == stb_k);
      end else begin
        // Odd phases only
        w[gen1_mrk_bit] = mrk_prev & ((k - on_k) % 2 == 1);
        w[gen1_stb_bit] = (k == stb_k);
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Beat comparison

  always @(negedge clk_wr) begin : compare_beats
    logic [st_w-1:0] got;
    got = {user_tvalid, user_tlast, user_tkeep, user_tdata};
    if (rst_n) begin
      if (rd_idx < exp_q.size() && due_q[rd_idx] <= cyc) begin
        assert (got == exp_q[rd_idx]) else begin
          beat_errors++;
          $display("Fail at %0t: beat %0d is %h, expected %h", $time, rd_idx, got,
                   exp_q[rd_idx]);
        end
        rd_idx++;
      end else begin
        assert (!user_tvalid) else begin
          beat_errors++;
          $display("Fail at %0t: user_tvalid high with no beat expected", $time);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic send_word(input logic [phy_w-1:0] w, input logic queue_it,
                           input logic [st_w-1:0] beat);
    @(posedge clk_wr);
    rx_phy0 <= w;
    // Input register plus output register
    last_due = cyc + 3;
    if (queue_it) begin
      exp_q.push_back(beat);
      due_q.push_back(last_due);
      if (beat[st_tvalid_bit]) begin
        exp_cnt++;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge clk_wr);
      n++;
    end while (rd_idx < exp_q.size() && n < 50);
    assert (rd_idx == exp_q.size()) else begin
      errors++;
      $display("Timeout: %0d expected beats never reached the user ports",
               exp_q.size() - rd_idx);
    end
  endtask

  task automatic check_count();
    assert (rx_st_debug_status[15:0] == exp_cnt[15:0]) else begin
      errors++;
      $display("Fail at %0t: beat count %0d, expected %0d", $time,
               rx_st_debug_status[15:0], exp_cnt[15:0]);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors + beat_errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors + beat_errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset();
    @(negedge clk_wr);
    assert (!user_tvalid && tx_phy0 == '0 && rx_st_debug_status == '0) else begin
      errors++;
      $display("Fail at %0t: outputs not idle after reset", $time);
    end
  endtask

  task automatic test_rx_online();
    logic [phy_w-1:0] w;
    logic             risen;
    int               n;
    @(posedge clk_wr);
    rx_online <= 1'b1;
    n = 0;
    risen = 1'b0;
    // Valid words here must be dropped
    while (!risen && n < 20) begin
      w = rand_phy();
      w[st_tvalid_bit] = 1'b1;
      send_word(w, 1'b0, '0);
      n++;
      @(negedge clk_wr);
      risen = rx_st_debug_status[16];
    end
    assert (risen) else begin
      errors++;
      $display("Timeout: rx online status never rose");
    end
    // First sample is one edge after the drive
    assert (n == dly_x + 1) else begin
      errors++;
      $display("Fail at %0t: rx online rose after %0d cycles, expected %0d", $time,
               n - 1, dly_x);
    end
    // Word driven on the rising edge is the first one decoded
    exp_q.push_back(ref_beat(w, '0, 1'b1));
    due_q.push_back(last_due);
    exp_cnt++;
  endtask

  task automatic test_gen2();
    logic [phy_w-1:0] w;
    for (int i = 0; i < 200; i++) begin
      w = rand_phy();
      w[st_tvalid_bit] = ($urandom_range(7, 0) != 0);
      send_word(w, 1'b1, ref_beat(w, '0, 1'b1));
    end
    send_word('0, 1'b0, '0);
    wait_drain();
    check_count();
  endtask

  task automatic test_gen1();
    logic [phy_w-1:0] lo;
    logic [phy_w-1:0] hi;
    int               n;
    @(posedge clk_wr);
    m_gen2_mode <= 1'b0;
    for (int i = 0; i < 100; i++) begin
      // Sometimes a newer low half replaces the first
      if ($urandom_range(3, 0) == 0) begin
        lo = rand_phy();
        lo[gen1_mrk_bit] = 1'b0;
        send_word(lo, 1'b0, '0);
      end
      lo = rand_phy();
      lo[gen1_mrk_bit] = 1'b0;
      send_word(lo, 1'b0, '0);
      hi = rand_phy();
      hi[gen1_mrk_bit] = 1'b1;
      // Top bit of the high half is tvalid
      hi[half_w-1] = ($urandom_range(7, 0) != 0);
      send_word(hi, 1'b1, ref_beat(hi, lo, 1'b0));
    end
    @(negedge clk_wr);
    assert (!rx_st_debug_status[18]) else begin
      errors++;
      $display("Fail at %0t: half-sync error set by paired words", $time);
    end
    // Lone high half right after a pair
    hi = rand_phy();
    hi[gen1_mrk_bit] = 1'b1;
    hi[half_w-1] = 1'b1;
    send_word(hi, 1'b0, '0);
    send_word('0, 1'b0, '0);
    n = 0;
    do begin
      @(negedge clk_wr);
      n++;
    end while (!rx_st_debug_status[18] && n < 10);
    assert (rx_st_debug_status[18]) else begin
      errors++;
      $display("Timeout: half-sync error never set by a lone marker word");
    end
    wait_drain();
    check_count();
  endtask

  task automatic tx_window(input logic gen2, input logic rand_mrk);
    logic             mrk_hist [0:tx_win];
    logic             mrk;
    logic             exp_on;
    logic [phy_w-1:0] exp_w;
    int               pulses;
    @(posedge clk_wr);
    mrk = rand_mrk ? ($urandom_range(1, 0) != 0) : 1'b1;
    tx_online      <= 1'b1;
    tx_mrk_userbit <= mrk;
    mrk_hist[0] = mrk;
    pulses = 0;
    for (int k = 1; k <= tx_win; k++) begin
      @(posedge clk_wr);
      mrk = rand_mrk ? ($urandom_range(1, 0) != 0) : 1'b1;
      tx_mrk_userbit <= mrk;
      mrk_hist[k] = mrk;
      @(negedge clk_wr);
      exp_w = tx_ref(k, gen2, mrk_hist[k-1]);
      if (tx_phy0[gen2 ? gen2_stb_bit : gen1_stb_bit]) begin
        pulses++;
      end
      assert (tx_phy0 == exp_w) else begin
        errors++;
        $display("Fail at %0t: tx_phy0 %h, expected %h", $time, tx_phy0, exp_w);
      end
      // Level rises dly_y cycles after the first sample
      exp_on = (k >= 1 + dly_y);
      assert (rx_st_debug_status[17] == exp_on) else begin
        errors++;
        $display("Fail at %0t: tx online status %0b, expected %0b", $time,
                 rx_st_debug_status[17], exp_on);
      end
    end
    assert (pulses == 1) else begin
      errors++;
      $display("Fail at %0t: strobe pulsed %0d times", $time, pulses);
    end
  endtask

  task automatic test_tx_sync();
    int n;
    @(posedge clk_wr);
    m_gen2_mode    <= 1'b1;
    tx_stb_userbit <= 1'b1;
    tx_window(1'b1, 1'b1);
    @(posedge clk_wr);
    tx_online      <= 1'b0;
    m_gen2_mode    <= 1'b0;
    tx_mrk_userbit <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_wr);
      n++;
    end while (tx_phy0 != '0 && n < 10);
    assert (tx_phy0 == '0) else begin
      errors++;
      $display("Timeout: tx_phy0 never went quiet after tx_online dropped");
    end
    // Constant marker shows the gen1 alternation
    tx_window(1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int seed_ret;
    int err_before;
    seed_ret = $urandom(56408);
    rst_n          <= 1'b0;
    tx_online      <= 1'b0;
    rx_online      <= 1'b0;
    rx_phy0        <= '0;
    m_gen2_mode    <= 1'b1;
    tx_mrk_userbit <= 1'b0;
    tx_stb_userbit <= 1'b0;
    delay_x_value  <= dly_w'(dly_x);
    delay_y_value  <= dly_w'(dly_y);
    delay_z_value  <= dly_w'(dly_z);
    repeat (3) @(posedge clk_wr);
    rst_n <= 1'b1;

    err_before = errors + beat_errors;
    test_reset();
    report_test("reset", err_before);
    err_before = errors + beat_errors;
    test_rx_online();
    report_test("rx online delay", err_before);
    err_before = errors + beat_errors;
    test_gen2();
    report_test("gen2 beats", err_before);
    err_before = errors + beat_errors;
    test_gen1();
    report_test("gen1 halves", err_before);
    err_before = errors + beat_errors;
    test_tx_sync();
    wait_drain();
    report_test("tx sync bits", err_before);

    $display("Tests run 5, tests failed %0d, errors %0d", tests_failed,
             errors + beat_errors);
    if (errors + beat_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/ll_pkg.sv
hdl/ll_auto_sync.sv
axi_st_d64_nordy_slave_concat/axi_st_d64_nordy_slave_concat.sv
hdl/axi_st_d64_nordy_slave_name.sv
hdl/axi_st_d64_nordy_slave_top.sv
bench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^All checks passed$" sim.log; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi
